//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_bw_monitor
FILELIST  ?= project.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- hw/bank_stats.sv
`timescale 1ns/100ps

module bank_stats #(
    parameter int n_banks = 4,
    parameter int count_w = 20
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [n_banks-1:0] rdy,
    input  logic               lvbl,
    stats_if.stats             st
);

    logic [n_banks-1:0] rdy_l;
    logic               lvbl_l;
    logic [n_banks-1:0] rise;
    logic               edge_now;
    logic               edge_q;
    logic               blank_start;
    logic [count_w-1:0] acc_active;
    logic [count_w-1:0] acc_blank;

    // Rising edges against the previous cycle.
    assign rise = rdy & ~rdy_l;

    // All banks merge into one event per cycle.
    // Otherwise only the selected bank is watched.
    always_comb begin
        if (st.all_banks) begin
            edge_now = |rise;
        end else begin
            edge_now = rise[st.bank];
        end
    end

    // First cycle with lvbl low.
    assign blank_start = !lvbl && lvbl_l;

    always_ff @(posedge clk) begin
        if (rst) begin
            rdy_l <= '0;
            lvbl_l <= 1'b1;
            edge_q <= 1'b0;
        end else begin
            rdy_l <= rdy;
            lvbl_l <= lvbl;
            edge_q <= edge_now;
        end
    end

    // Edges land one cycle late.
    // lvbl_l then holds the region the edge was seen in.
    always_ff @(posedge clk) begin
        if (rst) begin
            acc_active <= '0;
            acc_blank <= '0;
            st.avg_active <= '0;
            st.avg_blank <= '0;
            st.frames <= '0;
        end else if (blank_start) begin
            // New average is half the old one plus half the count.
            st.avg_active <= (st.avg_active >> 1) + (acc_active >> 1);
            st.avg_blank <= (st.avg_blank >> 1) + (acc_blank >> 1);
            st.frames <= st.frames + 1'b1;
            // Clearing wins over a pending increment.
            acc_active <= '0;
            acc_blank <= '0;
        end else if (edge_q) begin
            if (lvbl_l) begin
                acc_active <= acc_active + 1'b1;
            end else begin
                acc_blank <= acc_blank + 1'b1;
            end
        end
    end

    // Frame total trails the region averages by a cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            st.avg_frame <= '0;
        end else begin
            st.avg_frame <= st.avg_active + st.avg_blank;
        end
    end

endmodule

//--- hw/bw_monitor_top.sv
`timescale 1ns/100ps

module bw_monitor_top #(
    parameter int n_banks = 4,
    parameter int count_w = 20,
    parameter int h_total = 16,
    parameter int v_total = 12,
    parameter int v_active = 8
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [n_banks-1:0]              rdy,
    output logic                            lvbl,
    input  logic [mon_pkg::axil_addr_w-1:0] awaddr,
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [mon_pkg::axil_data_w-1:0] wdata,
    input  logic                            wvalid,
    output logic                            wready,
    output logic [1:0]                      bresp,
    output logic                            bvalid,
    input  logic                            bready,
    input  logic [mon_pkg::axil_addr_w-1:0] araddr,
    input  logic                            arvalid,
    output logic                            arready,
    output logic [mon_pkg::axil_data_w-1:0] rdata,
    output logic [1:0]                      rresp,
    output logic                            rvalid,
    input  logic                            rready
);

    // Selection out and statistics back.
    stats_if #(.count_w(count_w)) st_bus ();

    // Frame timing.
    // lvbl also leaves the chip.
    frame_timer #(
        .h_total(h_total),
        .v_total(v_total),
        .v_active(v_active)
    ) frame_timer_inst (
        .clk(clk),
        .rst(rst),
        .lvbl(lvbl)
    );

    bank_stats #(
        .n_banks(n_banks),
        .count_w(count_w)
    ) bank_stats_inst (
        .clk(clk),
        .rst(rst),
        .rdy(rdy),
        .lvbl(lvbl),
        .st(st_bus.stats)
    );

    // Host access.
    stats_axil_regs stats_axil_regs_inst (
        .clk(clk),
        .rst(rst),
        .awaddr(awaddr),
        .awvalid(awvalid),
        .awready(awready),
        .wdata(wdata),
        .wvalid(wvalid),
        .wready(wready),
        .bresp(bresp),
        .bvalid(bvalid),
        .bready(bready),
        .araddr(araddr),
        .arvalid(arvalid),
        .arready(arready),
        .rdata(rdata),
        .rresp(rresp),
        .rvalid(rvalid),
        .rready(rready),
        .st(st_bus.regs)
    );

endmodule

//--- hw/frame_timer.sv
`timescale 1ns/100ps

module frame_timer #(
    parameter int h_total = 16,
    parameter int v_total = 12,
    parameter int v_active = 8
) (
    input  logic clk,
    input  logic rst,
    output logic lvbl
);

    localparam int h_w = $clog2(h_total);
    localparam int v_w = $clog2(v_total);

    logic [h_w-1:0] h_cnt;
    logic [v_w-1:0] v_cnt;
    logic [v_w-1:0] v_next;
    logic line_end;
    logic frame_end;

    // Last pixel of a line and last line of a frame.
    assign line_end = h_cnt == h_w'(h_total - 1);
    assign frame_end = v_cnt == v_w'(v_total - 1);

    // Line number for the next cycle.
    always_comb begin
        if (!line_end) begin
            v_next = v_cnt;
        end else if (frame_end) begin
            v_next = '0;
        end else begin
            v_next = v_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
            // Line 0 is active.
            lvbl <= 1'b1;
        end else begin
            h_cnt <= line_end ? '0 : h_cnt + 1'b1;
            v_cnt <= v_next;
            // Registered so lvbl lines up with v_cnt.
            lvbl <= v_next < v_w'(v_active);
        end
    end

endmodule

//--- hw/mon_pkg.sv
package mon_pkg;

    // Bus widths of the AXI4-Lite register port.
    localparam int axil_addr_w = 8;
    localparam int axil_data_w = 32;

    // Register map.
    // Selection word with bit 0 for all banks and bits 2:1 for the bank.
    localparam logic [axil_addr_w-1:0] reg_select = 8'h00;

    // Averages over the whole frame and its two regions.
    localparam logic [axil_addr_w-1:0] reg_avg_frame = 8'h04;
    localparam logic [axil_addr_w-1:0] reg_avg_active = 8'h08;
    localparam logic [axil_addr_w-1:0] reg_avg_blank = 8'h0C;

    // Blank starts seen since reset.
    localparam logic [axil_addr_w-1:0] reg_frames = 8'h10;

    // Response codes on bresp and rresp.
    localparam logic [1:0] resp_okay = 2'd0;
    // Returned for any offset outside the map.
    localparam logic [1:0] resp_slverr = 2'd2;

endpackage

//--- hw/stats_axil_regs.sv
`timescale 1ns/100ps

module stats_axil_regs (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [mon_pkg::axil_addr_w-1:0] awaddr,
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [mon_pkg::axil_data_w-1:0] wdata,
    input  logic                            wvalid,
    output logic                            wready,
    output logic [1:0]                      bresp,
    output logic                            bvalid,
    input  logic                            bready,
    input  logic [mon_pkg::axil_addr_w-1:0] araddr,
    input  logic                            arvalid,
    output logic                            arready,
    output logic [mon_pkg::axil_data_w-1:0] rdata,
    output logic [1:0]                      rresp,
    output logic                            rvalid,
    input  logic                            rready,
    stats_if.regs                           st
);

    import mon_pkg::*;

    logic                   wr_accept;
    logic                   rd_accept;
    logic [axil_data_w-1:0] rd_data;
    logic [1:0]             rd_resp;

    // True for the five offsets in the map.
    function automatic logic is_mapped(input logic [axil_addr_w-1:0] addr);
        case (addr)
            reg_select, reg_avg_frame, reg_avg_active, reg_avg_blank, reg_frames:
                return 1'b1;
            default:
                return 1'b0;
        endcase
    endfunction

    // Address and data are taken together.
    // A pending response holds off the next write.
    assign wr_accept = awvalid && wvalid && !bvalid;
    assign awready = wr_accept;
    assign wready = wr_accept;

    // One read in flight.
    assign rd_accept = arvalid && !rvalid;
    assign arready = rd_accept;

    // Write channel and selection register.
    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
            st.all_banks <= 1'b1;
            st.bank <= 2'd0;
        end else begin
            if (wr_accept) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            // Only the selection word is writable.
            if (wr_accept && awaddr == reg_select) begin
                st.all_banks <= wdata[0];
                st.bank <= wdata[2:1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            bresp <= is_mapped(awaddr) ? resp_okay : resp_slverr;
        end
    end

    // Read mux with the statistics zero-extended.
    always_comb begin
        rd_data = '0;
        rd_resp = resp_okay;
        case (araddr)
            reg_select:     rd_data = axil_data_w'({st.bank, st.all_banks});
            reg_avg_frame:  rd_data = axil_data_w'(st.avg_frame);
            reg_avg_active: rd_data = axil_data_w'(st.avg_active);
            reg_avg_blank:  rd_data = axil_data_w'(st.avg_blank);
            reg_frames:     rd_data = axil_data_w'(st.frames);
            default:        rd_resp = resp_slverr;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (rd_accept) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // Data is sampled in the acceptance cycle and held until taken.
    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rdata <= rd_data;
            rresp <= rd_resp;
        end
    end

endmodule

//--- hw/stats_if.sv
`timescale 1ns/100ps

interface stats_if #(
    parameter int count_w = 20
);

    // Bank selection from the register block.
    logic all_banks;
    logic [1:0] bank;

    // Statistics from the counting block.
    logic [count_w-1:0] avg_frame;
    logic [count_w-1:0] avg_active;
    logic [count_w-1:0] avg_blank;
    logic [count_w-1:0] frames;

    modport regs (
        output all_banks, bank,
        input  avg_frame, avg_active, avg_blank, frames
    );

    modport stats (
        input  all_banks, bank,
        output avg_frame, avg_active, avg_blank, frames
    );

endinterface

//--- project.f
hw/mon_pkg.sv
hw/stats_if.sv
hw/frame_timer.sv
hw/bank_stats.sv
hw/stats_axil_regs.sv
hw/bw_monitor_top.sv
sim/bw_monitor_assertions.sv
sim/tb_bw_monitor.sv

//--- sim/bw_monitor_assertions.sv
`timescale 1ns/100ps

module bw_monitor_assertions #(
    parameter int h_total = 16,
    parameter int v_total = 12,
    parameter int v_active = 8
) (
    input logic        clk,
    input logic        rst,
    input logic        lvbl,
    input logic        bvalid,
    input logic        bready,
    input logic        rvalid,
    input logic        rready,
    input logic [31:0] rdata
);

    int fail_count = 0;

    // Next blank start comes one frame period later.
    a_frame_period: assert property (@(posedge clk) disable iff (rst)
        $fell(lvbl) |-> ##(h_total * v_total) $fell(lvbl)) else begin
        fail_count++;
        $error("blank period");
    end

    // Active part of the frame lasts v_active lines.
    a_active_len: assert property (@(posedge clk) disable iff (rst)
        $rose(lvbl) |-> ##(h_total * v_active) $fell(lvbl)) else begin
        fail_count++;
        $error("active length");
    end

    // Responses wait for their ready.
    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid) else begin
        fail_count++;
        $error("bvalid dropped");
    end
    a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid) else begin
        fail_count++;
        $error("rvalid dropped");
    end
    a_rdata_stable: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> $stable(rdata)) else begin
        fail_count++;
        $error("rdata changed");
    end

endmodule

bind bw_monitor_top bw_monitor_assertions #(
    .h_total(h_total),
    .v_total(v_total),
    .v_active(v_active)
) bw_monitor_assertions_inst (.*);

//--- sim/bw_monitor_patterns.txt
// sel act0 act1 act2 act3 blk0 blk1 blk2 blk3 avg_frame avg_active avg_blank
// sel bit 0 selects all banks, bits 2:1 the bank; averages follow the halving rule
1 3 7 2 5 4 1 0 2 5 3 2
1 A A 4 0 5 5 5 5 9 6 3
4 1 9 C 3 2 0 3 1 B 9 2
0 8 2 B 6 5 3 1 4 B 8 3
6 0 5 5 C 0 0 0 4 D A 3
2 6 B 1 7 3 5 2 0 D A 3
7 C 1 1 1 1 3 5 2 E B 3
1 0 0 0 0 0 0 0 0 6 5 1

//--- sim/tb_bw_monitor.sv
`timescale 1ns/100ps

module tb_bw_monitor;

    import mon_pkg::*;

    localparam int n_banks = 4;
    localparam int count_w = 20;
    localparam int h_total = 16;
    localparam int v_total = 12;
    localparam int n_pat = 8;
    // Pattern count plus two frames, at 4 ns per cycle, doubled.
    localparam real timeout_ns = (n_pat + 2) * h_total * v_total * 4.0 * 2.0;

    logic clk = 1'b0;
    logic rst;
    logic [n_banks-1:0] rdy;
    logic lvbl;
    logic [axil_addr_w-1:0] awaddr, araddr;
    logic [axil_data_w-1:0] wdata, rdata;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [1:0] bresp, rresp;

    // Per line: selection, 4 active counts, 4 blank counts, frame/active/blank averages.
    logic [31:0] pat [0:n_pat*12-1];
    integer seed = 845;
    int errors = 0;
    int tests = 0;
    int blank_seen = 0;
    logic lvbl_q;

    bw_monitor_top bw_monitor_top_inst (.*);

    initial begin
        forever #2 clk = ~clk;
    end

    initial begin
        #(timeout_ns);
        $display("watchdog expired before the tests finished");
        $display("TB FAILED");
        $finish;
    end

    // Independent count of blank starts seen on lvbl.
    always @(posedge clk) begin
        if (rst) begin
            lvbl_q <= 1'b1;
        end else begin
            lvbl_q <= lvbl;
            if (lvbl_q && !lvbl) blank_seen <= blank_seen + 1;
        end
    end

    task automatic check_avg(input string name, input logic [count_w-1:0] got,
                             input logic [count_w-1:0] exp);
        if (got !== exp) begin
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_sel(input string name, input logic [2:0] got, input logic [2:0] exp);
        if (got !== exp) begin
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int err0);
        tests++;
        if (errors == err0) $display("test %s: ok", name);
        else $display("test %s: failed", name);
    endtask

    // Random stretch of response back-pressure, then one ready cycle.
    task automatic take_response(input bit is_read);
        int hold;
        hold = $random(seed) & 3;
        repeat (hold) @(negedge clk);
        @(posedge clk);
        if (is_read) begin
            rready <= 1'b1;
        end else begin
            bready <= 1'b1;
        end
        @(posedge clk);
        rready <= 1'b0;
        bready <= 1'b0;
        @(negedge clk);
        if (is_read ? rvalid : bvalid) begin
            $display("response still valid after it was taken");
            errors++;
        end
    endtask

    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        @(posedge clk);
        awaddr <= addr;
        wdata <= data;
        awvalid <= 1'b1;
        wvalid <= 1'b1;
        @(negedge clk);
        while (!awready) @(negedge clk);
        // Both channels are taken in the same cycle.
        if (!wready) begin
            $display("wready did not rise together with awready");
            errors++;
        end
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid <= 1'b0;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        resp = bresp;
        take_response(1'b0);
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        @(posedge clk);
        araddr <= addr;
        arvalid <= 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        arvalid <= 1'b0;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        data = rdata;
        resp = rresp;
        take_response(1'b1);
    endtask

    task automatic wait_blank_start;
        int start;
        start = blank_seen;
        while (blank_seen == start) @(negedge clk);
    endtask

    // Pulse event k fires every bank whose count exceeds k, so banks overlap.
    task automatic pulse_banks(input int base);
        logic [n_banks-1:0] mask;
        int gap;
        for (int k = 0; k < 12; k++) begin
            mask = '0;
            for (int b = 0; b < n_banks; b++) begin
                if (pat[base+b] > k) mask[b] = 1'b1;
            end
            if (mask != '0) begin
                @(posedge clk);
                rdy <= mask;
                @(posedge clk);
                rdy <= '0;
                gap = $random(seed) & 1;
                repeat (gap) @(posedge clk);
            end
        end
    endtask

    initial begin
        logic [31:0] d;
        logic [1:0] r;
        int err0;
        int base;
        $readmemh("sim/bw_monitor_patterns.txt", pat);
        rst = 1'b1;
        rdy = '0;
        awaddr = '0;
        wdata = '0;
        awvalid = 1'b0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // Reset values.
        err0 = errors;
        axil_read(reg_avg_frame, d, r);
        check_avg("avg_frame", d[count_w-1:0], '0);
        axil_read(reg_avg_active, d, r);
        check_avg("avg_active", d[count_w-1:0], '0);
        axil_read(reg_avg_blank, d, r);
        check_avg("avg_blank", d[count_w-1:0], '0);
        axil_read(reg_frames, d, r);
        check_avg("frames", d[count_w-1:0], '0);
        axil_read(reg_select, d, r);
        check_sel("select", d[2:0], 3'h1);
        end_test("reset", err0);

        // Unmapped offsets.
        err0 = errors;
        axil_read(8'h14, d, r);
        check_resp("rresp", r, resp_slverr);
        check_avg("rdata", d[count_w-1:0], '0);
        axil_write(8'h20, 32'h6, r);
        check_resp("bresp", r, resp_slverr);
        axil_read(reg_select, d, r);
        check_sel("select", d[2:0], 3'h1);
        end_test("unmapped", err0);

        wait_blank_start();
        for (int p = 0; p < n_pat; p++) begin
            err0 = errors;
            base = p * 12;
            axil_write(reg_select, pat[base], r);
            check_resp("bresp", r, resp_okay);
            pulse_banks(base + 5);
            while (!lvbl) @(negedge clk);
            pulse_banks(base + 1);
            wait_blank_start();
            axil_read(reg_avg_frame, d, r);
            check_avg("avg_frame", d[count_w-1:0], pat[base+9][count_w-1:0]);
            axil_read(reg_avg_active, d, r);
            check_avg("avg_active", d[count_w-1:0], pat[base+10][count_w-1:0]);
            axil_read(reg_avg_blank, d, r);
            check_avg("avg_blank", d[count_w-1:0], pat[base+11][count_w-1:0]);
            check_resp("rresp", r, resp_okay);
            axil_read(reg_frames, d, r);
            check_avg("frames", d[count_w-1:0], count_w'(blank_seen));
            end_test($sformatf("frame %0d", p), err0);
        end

        // Failed assertions count as errors too.
        errors += bw_monitor_top_inst.bw_monitor_assertions_inst.fail_count;
        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
